/* source/icache_pkg.sv */
`default_nettype none

package icache_pkg;

    localparam int PADDR_BITS    = 32;
    localparam int LINE_WORDS    = 8;
    localparam int FETCH_WORDS   = 4;
    localparam int LINE_OFF_BITS = $clog2(LINE_WORDS) + 2; // Byte offset inside a line.

    typedef logic [31:0]                         word_t;
    typedef logic [PADDR_BITS-1:0]               paddr_t;
    typedef logic [PADDR_BITS-LINE_OFF_BITS-1:0] line_addr_t;
    typedef logic [$clog2(LINE_WORDS)-1:0]       word_off_t;
    typedef logic [2:0]                          fetch_cnt_t; // 1 to FETCH_WORDS.

    ////////////////////////////////////////////////////////////
    // Fetch side.
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        paddr_t     addr;
        fetch_cnt_t count;
    } fetch_req_t;

    // Slot 0 holds the word at addr.
    typedef struct packed {
        paddr_t                  addr;
        logic [FETCH_WORDS-1:0]  mask;
        word_t [FETCH_WORDS-1:0] data;
    } fetch_resp_t;

    typedef word_t [LINE_WORDS-1:0] line_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        MISS,
        RESPOND
    } cache_state_t;

endpackage

`default_nettype wire

/* source/icache_way.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_way #(
    parameter int SETS = 16,
    localparam int IDX_BITS = $clog2(SETS),
    localparam int TAG_BITS = icache_pkg::PADDR_BITS - icache_pkg::LINE_OFF_BITS - IDX_BITS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  rd_en,
    input  logic [IDX_BITS-1:0]   rd_index,
    input  logic                  wr_en,
    input  logic [IDX_BITS-1:0]   wr_index,
    input  logic [TAG_BITS-1:0]   wr_tag,
    input  icache_pkg::line_t     wr_line,
    output logic                  rd_valid,
    output logic [TAG_BITS-1:0]   rd_tag,
    output icache_pkg::line_t     rd_line
);
    typedef logic [TAG_BITS-1:0] tag_t;

    logic [SETS-1:0]   valid_q;
    tag_t              tag_mem  [SETS];
    icache_pkg::line_t data_mem [SETS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q  <= '0;
            rd_valid <= 1'b0;
        end else begin
            if (wr_en) valid_q[wr_index] <= 1'b1; // Whole line filled at once.
            if (rd_en) rd_valid <= valid_q[rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_index]  <= wr_tag;
            data_mem[wr_index] <= wr_line;
        end
        if (rd_en) begin
            rd_tag  <= tag_mem[rd_index];
            rd_line <= data_mem[rd_index];
        end
    end

endmodule

`default_nettype wire

/* source/plru_tree.sv */
`timescale 1ns/1ps
`default_nettype none

module plru_tree #(
    parameter int WAYS = 4,
    parameter int SETS = 16,
    localparam int IDX_BITS = $clog2(SETS),
    localparam int WAY_BITS = $clog2(WAYS)
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                touch_en,
    input  logic [IDX_BITS-1:0] touch_index,
    input  logic [WAY_BITS-1:0] touch_way,
    input  logic [IDX_BITS-1:0] victim_index,
    output logic [WAY_BITS-1:0] victim_way
);
    typedef logic [WAYS-2:0] tree_t; // Heap order with children 2n+1 and 2n+2 under node n.

    tree_t tree_q [SETS];
    tree_t tree_upd;
    tree_t tree_vic;

    // Point every node on the path away from the touched way.
    always_comb begin
        int node;
        node = 0;
        tree_upd = tree_q[touch_index];
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            tree_upd[node] = ~touch_way[WAY_BITS-1-lvl];
            node = 2 * node + 1 + int'(touch_way[WAY_BITS-1-lvl]);
        end
    end

    always_comb begin
        int node;
        node = 0;
        tree_vic = tree_q[victim_index];
        victim_way = '0;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            victim_way[WAY_BITS-1-lvl] = tree_vic[node];
            node = 2 * node + 1 + int'(tree_vic[node]);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch_en) begin
            tree_q[touch_index] <= tree_upd;
        end
    end

    a_ways_pow2: assert property (@(posedge clk) disable iff (rst)
        WAYS >= 2 && (WAYS & (WAYS - 1)) == 0)
        else $error("plru_tree needs a power-of-two way count");

endmodule

`default_nettype wire

/* source/line_refill.sv */
`timescale 1ns/1ps
`default_nettype none

module line_refill (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  icache_pkg::line_addr_t start_addr,
    output logic                   mem_ar_valid,
    output icache_pkg::line_addr_t mem_ar_addr,
    input  logic                   mem_ar_ready,
    input  logic                   mem_r_valid,
    input  icache_pkg::word_t      mem_r_data,
    input  logic                   mem_r_last,
    output logic                   done,
    output icache_pkg::line_t      line
);
    typedef enum logic [1:0] {
        RF_IDLE,
        RF_ADDR,
        RF_DATA
    } refill_state_t;

    refill_state_t         state;
    icache_pkg::word_off_t beat;

    assign mem_ar_valid = (state == RF_ADDR);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= RF_IDLE;
            beat  <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                RF_IDLE: if (start) state <= RF_ADDR;
                RF_ADDR: begin
                    beat <= '0;
                    if (mem_ar_ready) state <= RF_DATA;
                end
                RF_DATA: begin
                    if (mem_r_valid) begin
                        beat <= beat + 1'b1;
                        if (beat == icache_pkg::word_off_t'(icache_pkg::LINE_WORDS - 1)) begin
                            state <= RF_IDLE;
                            done  <= 1'b1; // Line is complete in the next cycle.
                        end
                    end
                end
                default: state <= RF_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RF_IDLE && start) mem_ar_addr <= start_addr;
        if (state == RF_DATA && mem_r_valid) line[beat] <= mem_r_data;
    end

    ////////////////////////////////////////////////////////////
    // Burst protocol checks.
    ////////////////////////////////////////////////////////////

    a_no_stray_beat: assert property (@(posedge clk) disable iff (rst)
        mem_r_valid |-> state == RF_DATA);

    a_last_on_count: assert property (@(posedge clk) disable iff (rst)
        mem_r_valid |-> mem_r_last == (beat == icache_pkg::word_off_t'(icache_pkg::LINE_WORDS - 1)));

    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        start |-> state == RF_IDLE);

endmodule

`default_nettype wire

/* source/icache.sv */
`timescale 1ns/1ps
`default_nettype none

module icache #(
    parameter int WAYS = 4,
    parameter int SETS = 16,
    localparam int IDX_BITS = $clog2(SETS),
    localparam int WAY_BITS = $clog2(WAYS),
    localparam int TAG_BITS = icache_pkg::PADDR_BITS - icache_pkg::LINE_OFF_BITS - IDX_BITS
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  icache_pkg::fetch_req_t  req,
    output logic                    req_ready,
    output logic                    resp_valid,
    output icache_pkg::fetch_resp_t resp,
    input  logic                    stall,
    input  logic                    flush,
    output logic                    refill_start,
    output icache_pkg::line_addr_t  refill_addr,
    input  logic                    refill_done,
    input  icache_pkg::line_t       refill_line
);
    typedef logic [IDX_BITS-1:0] set_idx_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [WAY_BITS-1:0] way_idx_t;
    typedef logic [icache_pkg::FETCH_WORDS-1:0] slot_mask_t;

    typedef struct packed {
        icache_pkg::paddr_t    addr;
        set_idx_t              index;
        tag_t                  tag;
        icache_pkg::word_off_t offset;
        slot_mask_t            mask;
    } req_buf_t;

    icache_pkg::cache_state_t state;
    req_buf_t                 req_buf;
    logic                     live;       // Low for one cycle out of reset.
    logic                     flush_seen;
    way_idx_t                 victim_q;

    set_idx_t              req_index;
    tag_t                  req_tag;
    icache_pkg::word_off_t req_off;
    slot_mask_t            req_mask;

    logic [WAYS-1:0]   way_valid;
    tag_t              way_tag  [WAYS];
    icache_pkg::line_t way_line [WAYS];
    logic [WAYS-1:0]   hit_vec;
    logic              hit;
    way_idx_t          hit_way;
    way_idx_t          victim_way;

    logic                    accept;
    logic                    lookup_go;
    logic                    fill_write;
    logic                    fill_resp;
    icache_pkg::line_t       src_line;
    icache_pkg::fetch_resp_t next_resp;

    assign req_index = req.addr[icache_pkg::LINE_OFF_BITS +: IDX_BITS];
    assign req_tag   = req.addr[icache_pkg::PADDR_BITS-1 -: TAG_BITS];
    assign req_off   = req.addr[icache_pkg::LINE_OFF_BITS-1:2];

    // Count clipped at the line end.
    always_comb begin
        for (int i = 0; i < icache_pkg::FETCH_WORDS; i++) begin
            req_mask[i] = (i < int'(req.count)) && (int'(req_off) + i < icache_pkg::LINE_WORDS);
        end
    end

    ////////////////////////////////////////////////////////////
    // Ways and replacement.
    ////////////////////////////////////////////////////////////

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        icache_way #(.SETS(SETS)) way_i (
            .clk      (clk),
            .rst      (rst),
            .rd_en    (accept),
            .rd_index (req_index),
            .wr_en    (fill_write && victim_q == way_idx_t'(w)),
            .wr_index (req_buf.index),
            .wr_tag   (req_buf.tag),
            .wr_line  (refill_line),
            .rd_valid (way_valid[w]),
            .rd_tag   (way_tag[w]),
            .rd_line  (way_line[w])
        );
        assign hit_vec[w] = way_valid[w] && (way_tag[w] == req_buf.tag);
    end

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (hit_vec[w]) hit_way = way_idx_t'(w);
        end
    end

    assign hit = |hit_vec;

    plru_tree #(.WAYS(WAYS), .SETS(SETS)) plru_i (
        .clk          (clk),
        .rst          (rst),
        .touch_en     (lookup_go || fill_write),
        .touch_index  (req_buf.index),
        .touch_way    (fill_write ? victim_q : hit_way),
        .victim_index (req_buf.index),
        .victim_way   (victim_way)
    );

    ////////////////////////////////////////////////////////////
    // Control.
    ////////////////////////////////////////////////////////////

    assign req_ready = live && !stall && !flush
                       && (state == icache_pkg::IDLE || (state == icache_pkg::LOOKUP && hit));
    assign accept     = req_valid && req_ready;
    assign lookup_go  = state == icache_pkg::LOOKUP && hit && !stall && !flush;
    assign fill_write = state == icache_pkg::MISS && refill_done;
    assign fill_resp  = !stall && !flush
                        && ((fill_write && !flush_seen)
                            || (state == icache_pkg::RESPOND && !resp_valid));

    assign refill_start = state == icache_pkg::LOOKUP && !hit && !stall && !flush;
    assign refill_addr  = {req_buf.tag, req_buf.index};

    // Rotate the line so slot 0 is the start word.
    assign src_line = (state == icache_pkg::LOOKUP) ? way_line[hit_way] : refill_line;
    always_comb begin
        next_resp.addr = req_buf.addr;
        next_resp.mask = req_buf.mask;
        for (int i = 0; i < icache_pkg::FETCH_WORDS; i++) begin
            next_resp.data[i] = req_buf.mask[i]
                ? src_line[icache_pkg::word_off_t'(int'(req_buf.offset) + i)] : '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= icache_pkg::IDLE;
            live       <= 1'b0;
            flush_seen <= 1'b0;
            victim_q   <= '0;
        end else begin
            live       <= 1'b1;
            flush_seen <= (state == icache_pkg::MISS) && (flush_seen || flush);
            case (state)
                icache_pkg::IDLE: if (accept) state <= icache_pkg::LOOKUP;
                icache_pkg::LOOKUP: begin
                    if (flush) begin
                        state <= icache_pkg::IDLE;
                    end else if (!stall) begin
                        if (!hit) begin
                            state    <= icache_pkg::MISS;
                            victim_q <= victim_way;
                        end else if (!accept) begin
                            state <= icache_pkg::IDLE;
                        end
                    end
                end
                icache_pkg::MISS: begin
                    if (refill_done) begin
                        state <= (flush_seen || flush) ? icache_pkg::IDLE : icache_pkg::RESPOND;
                    end
                end
                icache_pkg::RESPOND: begin
                    if (flush || (!stall && resp_valid)) state <= icache_pkg::IDLE;
                end
                default: state <= icache_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (flush) begin
            resp_valid <= 1'b0;
        end else if (!stall) begin
            resp_valid <= lookup_go || fill_resp; // Held while stalled.
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_buf.addr   <= req.addr;
            req_buf.index  <= req_index;
            req_buf.tag    <= req_tag;
            req_buf.offset <= req_off;
            req_buf.mask   <= req_mask;
        end
        if (lookup_go || fill_resp) resp <= next_resp;
    end

    a_one_hit: assert property (@(posedge clk) disable iff (rst)
        state == icache_pkg::LOOKUP |-> $onehot0(hit_vec));

    a_resp_mask: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> |resp.mask);

endmodule

`default_nettype wire

/* source/icache_top.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
    parameter int WAYS = 4,
    parameter int SETS = 16
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req_valid,
    input  icache_pkg::fetch_req_t  req,
    output logic                    req_ready,
    output logic                    resp_valid,
    output icache_pkg::fetch_resp_t resp,
    input  logic                    stall,
    input  logic                    flush,
    output logic                    mem_ar_valid,
    output icache_pkg::line_addr_t  mem_ar_addr,
    input  logic                    mem_ar_ready,
    input  logic                    mem_r_valid,
    input  icache_pkg::word_t       mem_r_data,
    input  logic                    mem_r_last
);
    logic                   refill_start;
    icache_pkg::line_addr_t refill_addr;
    logic                   refill_done;
    icache_pkg::line_t      refill_line;

    icache #(.WAYS(WAYS), .SETS(SETS)) icache_i (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .stall        (stall),
        .flush        (flush),
        .refill_start (refill_start),
        .refill_addr  (refill_addr),
        .refill_done  (refill_done),
        .refill_line  (refill_line)
    );

    line_refill refill_i (
        .clk          (clk),
        .rst          (rst),
        .start        (refill_start),
        .start_addr   (refill_addr),
        .mem_ar_valid (mem_ar_valid),
        .mem_ar_addr  (mem_ar_addr),
        .mem_ar_ready (mem_ar_ready),
        .mem_r_valid  (mem_r_valid),
        .mem_r_data   (mem_r_data),
        .mem_r_last   (mem_r_last),
        .done         (refill_done),
        .line         (refill_line)
    );

endmodule

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

/* sim/icache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_tb;
    localparam int WAYS         = 4;
    localparam int SETS         = 16;
    localparam int IDX_BITS     = $clog2(SETS);
    localparam int LA_BITS      = icache_pkg::PADDR_BITS - icache_pkg::LINE_OFF_BITS;
    localparam int TAG_SHIFT    = icache_pkg::LINE_OFF_BITS + IDX_BITS;
    localparam int CLK_NS       = 4;
    localparam int RESET_CYC    = 16;
    localparam int NUM_REQS     = 400;
    localparam int AR_WAIT_MAX  = 3;
    localparam int GAP_MAX      = 2;
    localparam int REFILL_WORST = AR_WAIT_MAX + icache_pkg::LINE_WORDS * (GAP_MAX + 1) + 4;
    localparam int WATCHDOG_NS  = (RESET_CYC + 16 + NUM_REQS * (REFILL_WORST + 20)) * CLK_NS;
    localparam icache_pkg::paddr_t ADDR_BASE = 32'h0004_0000;

    typedef logic [LA_BITS-IDX_BITS-1:0] tag_t;

    logic                    clk;
    logic                    rst;
    logic                    req_valid;
    icache_pkg::fetch_req_t  req;
    logic                    req_ready;
    logic                    resp_valid;
    icache_pkg::fetch_resp_t resp;
    logic                    stall;
    logic                    flush;
    logic                    mem_ar_valid;
    icache_pkg::line_addr_t  mem_ar_addr;
    logic                    mem_ar_ready;
    logic                    mem_r_valid;
    icache_pkg::word_t       mem_r_data;
    logic                    mem_r_last;

    integer            seed;
    icache_pkg::word_t mem_q [256];

    // Reference model state.
    logic       model_valid [SETS][WAYS];
    tag_t       model_tag   [SETS][WAYS];
    logic [2:0] model_tree  [SETS]; // Root, left node, right node.

    icache_pkg::fetch_resp_t exp_resp_q [$];
    int                      exp_due_q  [$]; // Cycle a hit response is due or -1 if open.
    icache_pkg::line_addr_t  burst_q    [$];

    int                      cyc;
    int                      made_n;
    int                      accepted_n;
    int                      hit_n;
    int                      flush_n;
    logic                    req_taken;
    logic [7:0]              req_pos;
    logic [7:0]              last_pos;
    int                      last_cnt;
    logic                    miss_open;
    logic [4:0]              miss_line;
    logic                    revisit_open;
    logic [4:0]              revisit_line;
    int                      ar_wait;
    int                      beats_left;
    int                      beat;
    int                      gap_run;
    icache_pkg::line_addr_t  burst_la;
    logic                    prev_stall;
    logic                    prev_resp_valid;
    icache_pkg::fetch_resp_t prev_resp;

    tb_clock_gen #(.PERIOD_NS(CLK_NS)) clock_i (.clk(clk));

    icache_top #(.WAYS(WAYS), .SETS(SETS)) dut_i (
        .clk          (clk),
        .rst          (rst),
        .req_valid    (req_valid),
        .req          (req),
        .req_ready    (req_ready),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .stall        (stall),
        .flush        (flush),
        .mem_ar_valid (mem_ar_valid),
        .mem_ar_addr  (mem_ar_addr),
        .mem_ar_ready (mem_ar_ready),
        .mem_r_valid  (mem_r_valid),
        .mem_r_data   (mem_r_data),
        .mem_r_last   (mem_r_last)
    );

    ////////////////////////////////////////////////////////////
    // Checks.
    ////////////////////////////////////////////////////////////

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_resp(input string name, input icache_pkg::fetch_resp_t got,
                              input icache_pkg::fetch_resp_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_line_addr(input string name, input icache_pkg::line_addr_t got,
                                   input icache_pkg::line_addr_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Model.
    ////////////////////////////////////////////////////////////

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    // Random contents mixed with the full word address.
    function automatic icache_pkg::word_t mem_word(input icache_pkg::line_addr_t la,
                                                   input int b);
        logic [7:0] pos;
        pos = {la[6:4], la[1:0], 3'(b)};
        return mem_q[pos] ^ {la, 3'(b), 2'b00};
    endfunction

    function automatic int plru_victim(input logic [2:0] t);
        return t[0] ? 2 + int'(t[2]) : int'(t[1]);
    endfunction

    function automatic logic [2:0] plru_touch(input logic [2:0] t, input int way);
        logic [2:0] n;
        n = t;
        n[0] = (way < 2); // Root points at the other half.
        if (way < 2) n[1] = (way == 0);
        else n[2] = (way == 2);
        return n;
    endfunction

    task automatic predict_request(input icache_pkg::fetch_req_t r);
        icache_pkg::line_addr_t  la;
        icache_pkg::fetch_resp_t e;
        tag_t                    tag;
        int                      set;
        int                      way;
        int                      off;
        logic                    hit;
        la  = r.addr[icache_pkg::PADDR_BITS-1:icache_pkg::LINE_OFF_BITS];
        set = int'(la[IDX_BITS-1:0]);
        tag = la[LA_BITS-1:IDX_BITS];
        off = int'(r.addr[icache_pkg::LINE_OFF_BITS-1:2]);
        hit = 1'b0;
        way = 0;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[set][w] && model_tag[set][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            way = plru_victim(model_tree[set]);
            model_valid[set][way] = 1'b1;
            model_tag[set][way]   = tag;
            burst_q.push_back(la);
        end
        model_tree[set] = plru_touch(model_tree[set], way);
        e.addr = r.addr;
        e.mask = '0;
        e.data = '0;
        for (int i = 0; i < icache_pkg::FETCH_WORDS; i++) begin
            if (i < int'(r.count) && off + i < icache_pkg::LINE_WORDS) begin
                e.mask[i] = 1'b1;
                e.data[i] = mem_word(la, off + i);
            end
        end
        exp_resp_q.push_back(e);
        exp_due_q.push_back(hit ? cyc + 2 : -1);
        miss_open = !hit;
        if (hit) hit_n++;
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus and memory.
    ////////////////////////////////////////////////////////////

    task automatic make_request();
        logic [7:0] pos;
        int         kind;
        kind = rand_below(4);
        if (revisit_open) begin
            pos = {revisit_line, 3'(rand_below(8))}; // Line left by a flushed miss.
            revisit_open = 1'b0;
        end else if (kind < 2) begin
            pos = last_pos + 8'(last_cnt); // Sequential fetch.
        end else begin
            pos = 8'(rand_below(256));
        end
        req.addr  = ADDR_BASE
                    | (icache_pkg::paddr_t'(pos[7:5]) << TAG_SHIFT)
                    | (icache_pkg::paddr_t'(pos[4:3]) << icache_pkg::LINE_OFF_BITS)
                    | (icache_pkg::paddr_t'(pos[2:0]) << 2);
        req.count = icache_pkg::fetch_cnt_t'(1 + rand_below(icache_pkg::FETCH_WORDS));
        req_valid = 1'b1;
        req_pos   = pos;
        last_pos  = pos;
        last_cnt  = int'(req.count);
        made_n++;
    endtask

    task automatic drive_inputs();
        if (req_taken) begin
            req_valid = 1'b0;
            req_taken = 1'b0;
        end
        if (!req_valid && made_n < NUM_REQS && rand_below(4) != 0) make_request();
        stall = (rand_below(8) == 0);
        flush = 1'b0;
        if (beats_left > 0 && miss_open && rand_below(6) == 0) begin
            flush     = 1'b1;
            miss_open = 1'b0;
            void'(exp_resp_q.pop_back());
            void'(exp_due_q.pop_back());
            revisit_open = 1'b1;
            revisit_line = miss_line;
            flush_n++;
        end

        mem_ar_ready = 1'b0;
        if (mem_ar_valid) begin
            if (ar_wait < 0) ar_wait = rand_below(AR_WAIT_MAX + 1);
            if (ar_wait == 0) mem_ar_ready = 1'b1;
            else ar_wait--;
        end
        mem_r_valid = 1'b0;
        mem_r_data  = '0;
        mem_r_last  = 1'b0;
        if (beats_left > 0) begin
            if (gap_run >= GAP_MAX || rand_below(4) != 0) begin
                mem_r_valid = 1'b1;
                mem_r_data  = mem_word(burst_la, beat);
                mem_r_last  = (beat == icache_pkg::LINE_WORDS - 1);
                gap_run     = 0;
            end else begin
                gap_run++;
            end
        end
    endtask

    task automatic observe_outputs();
        icache_pkg::fetch_resp_t e;
        int                      due;
        if (prev_stall) begin // Frozen output.
            check_flag("resp_valid", resp_valid, prev_resp_valid);
            if (prev_resp_valid) check_resp("resp", resp, prev_resp);
        end
        if (stall) check_flag("req_ready", req_ready, 1'b0);
        if (resp_valid && !stall) begin
            if (exp_resp_q.size() == 0) begin
                $display("Response at %0t ns with no request outstanding", $time);
                abort_run();
            end
            e   = exp_resp_q.pop_front();
            due = exp_due_q.pop_front();
            check_resp("resp", resp, e);
            if (due >= 0 && due != cyc) begin
                $display("Hit response at %0t ns came in cycle %0d, expected cycle %0d",
                         $time, cyc, due);
                abort_run();
            end
        end
        if (stall) begin
            foreach (exp_due_q[i]) exp_due_q[i] = -1;
        end
        if (req_valid && req_ready) begin
            if (burst_q.size() != 0) begin
                $display("Request accepted at %0t ns before the predicted burst", $time);
                abort_run();
            end
            predict_request(req);
            if (miss_open) miss_line = req_pos[7:3];
            accepted_n++;
            req_taken = 1'b1;
        end
        if (mem_ar_valid && mem_ar_ready) begin
            if (burst_q.size() == 0) begin
                $display("Burst at %0t ns for a request the model predicts to hit", $time);
                abort_run();
            end
            check_line_addr("mem_ar_addr", mem_ar_addr, burst_q.pop_front());
            burst_la   = mem_ar_addr;
            beat       = 0;
            beats_left = icache_pkg::LINE_WORDS;
            ar_wait    = -1;
            gap_run    = 0;
        end
        if (mem_r_valid) begin
            beat++;
            beats_left--;
        end
        prev_stall      = stall;
        prev_resp_valid = resp_valid;
        prev_resp       = resp;
    endtask

    task automatic step_cycle();
        @(negedge clk);
        drive_inputs();
        #1;
        observe_outputs();
        cyc++;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout after %0d ns, the run did not complete", WATCHDOG_NS);
        abort_run();
    end

    initial begin
        seed         = 32'h3c4d_0c5e;
        rst          = 1'b1;
        req_valid    = 1'b0;
        req          = '0;
        stall        = 1'b0;
        flush        = 1'b0;
        mem_ar_ready = 1'b0;
        mem_r_valid  = 1'b0;
        mem_r_data   = '0;
        mem_r_last   = 1'b0;
        cyc          = 0;
        made_n       = 0;
        accepted_n   = 0;
        hit_n        = 0;
        flush_n      = 0;
        req_taken    = 1'b0;
        req_pos      = '0;
        last_pos     = '0;
        last_cnt     = 0;
        miss_open    = 1'b0;
        miss_line    = '0;
        revisit_open = 1'b0;
        revisit_line = '0;
        ar_wait      = -1;
        beats_left   = 0;
        beat         = 0;
        gap_run      = 0;
        burst_la     = '0;
        prev_stall      = 1'b0;
        prev_resp_valid = 1'b0;
        prev_resp       = '0;
        for (int i = 0; i < 256; i++) mem_q[i] = $random(seed);
        for (int s = 0; s < SETS; s++) begin
            model_tree[s] = '0;
            for (int w = 0; w < WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end

        repeat (RESET_CYC) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            #1;
            check_flag("resp_valid", resp_valid, 1'b0);
            check_flag("mem_ar_valid", mem_ar_valid, 1'b0);
        end

        while (accepted_n < NUM_REQS || exp_resp_q.size() != 0
               || beats_left != 0 || burst_q.size() != 0) begin
            step_cycle();
        end
        repeat (8) step_cycle(); // Nothing may follow the last response.

        $display("%0d requests, %0d hits, %0d flushed misses", accepted_n, hit_n, flush_n);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
source/icache_pkg.sv
source/icache_way.sv
source/plru_tree.sv
source/line_refill.sv
source/icache.sv
source/icache_top.sv
sim/tb_clock_gen.sv
sim/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the icache testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module icache_tb \
    --Mdir obj_dir -o icache_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/icache_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test passed$" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
